//--- hdl/cb_macros.svh
// Completion subsystem sizes
`ifndef CB_MACROS_SVH
`define CB_MACROS_SVH

// Data path width
`define CB_XLEN 32

// Completion buffer entries, power of two
`define CB_DEPTH 8

// Execution unit latencies in cycles
`define CB_ADD_LAT 1
`define CB_MUL_LAT 3

`endif

//--- hdl/cb_pkg.sv
// Completion subsystem types
`default_nettype none
`include "cb_macros.svh"

package cb_pkg;

  // Slot index width
  localparam int TAG_W = $clog2(`CB_DEPTH);

  typedef logic [`CB_XLEN-1:0] word_t;
  typedef logic [TAG_W-1:0] tag_t;
  // Extra wrap bit tells full from empty
  typedef logic [TAG_W:0] ptr_t;
  typedef logic [4:0] reg_idx_t;

  // One buffer slot
  typedef struct packed {
    word_t data;
    reg_idx_t rd;
    logic busy;       // slot allocated
    logic done;       // result written back
    logic exception;
  } cb_entry_t;

endpackage

`default_nettype wire

//--- hdl/exec_unit.sv
// Fixed latency arithmetic unit
`timescale 1ns/1ps
`default_nettype none

module exec_unit #(
  parameter int LATENCY = 1,
  parameter bit MUL     = 1'b0
) (
  input  wire logic             CLK,
  input  wire logic             nRST,
  input  wire logic             flush,
  input  wire logic             in_valid,
  input  wire cb_pkg::tag_t     in_tag,
  input  wire cb_pkg::word_t    in_a,
  input  wire cb_pkg::word_t    in_b,
  input  wire cb_pkg::reg_idx_t in_rd,
  input  wire logic             in_exc,
  output logic                  out_valid,
  output cb_pkg::tag_t          out_tag,
  output cb_pkg::word_t         out_data,
  output cb_pkg::reg_idx_t      out_rd,
  output logic                  out_exc
);

  // One entry per pipeline stage
  logic             valid_q [LATENCY];
  cb_pkg::tag_t     tag_q   [LATENCY];
  cb_pkg::word_t    data_q  [LATENCY];
  cb_pkg::reg_idx_t rd_q    [LATENCY];
  logic             exc_q   [LATENCY];
  cb_pkg::word_t    result;

  // Low word of sum or product
  assign result = MUL ? cb_pkg::word_t'(in_a * in_b) : cb_pkg::word_t'(in_a + in_b);

  // Valid chain, cleared on flush
  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      for (int s = 0; s < LATENCY; s++) begin
        valid_q[s] <= 1'b0;
      end
    end else if (flush) begin
      for (int s = 0; s < LATENCY; s++) begin
        valid_q[s] <= 1'b0;
      end
    end else begin
      valid_q[0] <= in_valid;
      for (int s = 1; s < LATENCY; s++) begin
        valid_q[s] <= valid_q[s-1];
      end
    end
  end

  // Payload moves along with its valid bit
  always_ff @(posedge CLK) begin
    tag_q[0]  <= in_tag;
    data_q[0] <= result;
    rd_q[0]   <= in_rd;
    exc_q[0]  <= in_exc;
    for (int s = 1; s < LATENCY; s++) begin
      tag_q[s]  <= tag_q[s-1];
      data_q[s] <= data_q[s-1];
      rd_q[s]   <= rd_q[s-1];
      exc_q[s]  <= exc_q[s-1];
    end
  end

  // Last stage is the writeback
  assign out_valid = valid_q[LATENCY-1];
  assign out_tag   = tag_q[LATENCY-1];
  assign out_data  = data_q[LATENCY-1];
  assign out_rd    = rd_q[LATENCY-1];
  assign out_exc   = exc_q[LATENCY-1];

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
// Integer register file
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  wire logic             CLK,
  input  wire logic             nRST,
  input  wire logic             wen,
  input  wire cb_pkg::reg_idx_t waddr,
  input  wire cb_pkg::word_t    wdata,
  input  wire cb_pkg::reg_idx_t raddr,
  output cb_pkg::word_t         rdata
);

  localparam int NUM_REGS = 32;

  cb_pkg::word_t regs [NUM_REGS];

  // Register 0 is never written, so it stays zero
  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      for (int r = 0; r < NUM_REGS; r++) begin
        regs[r] <= '0;
      end
    end else if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // Asynchronous read port
  assign rdata = regs[raddr];

endmodule

`default_nettype wire

//--- hdl/completion_buffer.sv
// In-order completion buffer
`timescale 1ns/1ps
`default_nettype none
`include "cb_macros.svh"

module completion_buffer (
  input  wire logic             CLK,
  input  wire logic             nRST,
  // Allocation at the tail
  input  wire logic             alloc,
  input  wire cb_pkg::reg_idx_t alloc_rd,
  input  wire logic             alloc_exc,
  // Add unit writeback
  input  wire logic             add_valid,
  input  wire cb_pkg::tag_t     add_tag,
  input  wire cb_pkg::word_t    add_data,
  input  wire cb_pkg::reg_idx_t add_rd,
  input  wire logic             add_exc,
  // Multiply unit writeback
  input  wire logic             mul_valid,
  input  wire cb_pkg::tag_t     mul_tag,
  input  wire cb_pkg::word_t    mul_data,
  input  wire cb_pkg::reg_idx_t mul_rd,
  input  wire logic             mul_exc,
  // Status and commit
  output cb_pkg::tag_t          alloc_tag,
  output logic                  full,
  output logic                  empty,
  output logic                  commit_valid,
  output cb_pkg::reg_idx_t      commit_rd,
  output cb_pkg::word_t         commit_data,
  output logic                  commit_exception,
  output logic                  rf_wen,
  output logic                  flush
);

  localparam int DEPTH = `CB_DEPTH;
  localparam int TW = cb_pkg::TAG_W;

  cb_pkg::cb_entry_t cb_q [DEPTH];
  cb_pkg::cb_entry_t cb_d [DEPTH];
  cb_pkg::ptr_t      head;
  cb_pkg::ptr_t      tail;
  cb_pkg::ptr_t      head_d;
  cb_pkg::ptr_t      tail_d;
  cb_pkg::tag_t      head_sel;
  cb_pkg::cb_entry_t head_entry;
  logic              do_alloc;
  logic              retire;

  // Slot selects drop the wrap bit
  assign head_sel  = head[TW-1:0];
  assign alloc_tag = tail[TW-1:0];
  assign head_entry = cb_q[head_sel];

  // Same slot, different lap means full
  assign full  = (head[TW-1:0] == tail[TW-1:0]) && (head[TW] != tail[TW]);
  assign empty = (head == tail);

  // Issue while full is dropped here
  assign do_alloc = alloc & ~full;

  // Head entry finished this cycle
  assign commit_valid     = head_entry.busy & head_entry.done;
  assign commit_exception = commit_valid & head_entry.exception;
  assign commit_rd        = head_entry.rd;
  assign commit_data      = head_entry.data;

  // Faulting entry squashes everything younger
  assign flush = commit_exception;

  // Normal retirement into the register file
  assign retire = commit_valid & ~head_entry.exception;
  assign rf_wen = retire;

  always_comb begin
    cb_d   = cb_q;
    head_d = head;
    tail_d = tail;

    // Free the head slot on retirement
    if (retire) begin
      cb_d[head_sel] = '0;
      head_d = head + 1'b1;
    end

    // New slot at the tail, waiting on a result
    if (do_alloc) begin
      cb_d[alloc_tag].busy      = 1'b1;
      cb_d[alloc_tag].done      = 1'b0;
      cb_d[alloc_tag].rd        = alloc_rd;
      cb_d[alloc_tag].exception = alloc_exc;
      tail_d = tail + 1'b1;
    end

    // Add result by tag
    if (add_valid) begin
      cb_d[add_tag].data      = add_data;
      cb_d[add_tag].rd        = add_rd;
      cb_d[add_tag].exception = add_exc;
      cb_d[add_tag].done      = 1'b1;
    end

    // Multiply result by tag, never the same slot as add
    if (mul_valid) begin
      cb_d[mul_tag].data      = mul_data;
      cb_d[mul_tag].rd        = mul_rd;
      cb_d[mul_tag].exception = mul_exc;
      cb_d[mul_tag].done      = 1'b1;
    end

    // Flush wins over every other update
    if (flush) begin
      for (int i = 0; i < DEPTH; i++) begin
        cb_d[i] = '0;
      end
      head_d = '0;
      tail_d = '0;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      head <= '0;
      tail <= '0;
      for (int i = 0; i < DEPTH; i++) begin
        cb_q[i] <= '0;
      end
    end else begin
      head <= head_d;
      tail <= tail_d;
      cb_q <= cb_d;
    end
  end

endmodule

`default_nettype wire

//--- hdl/cb_top.sv
// Completion subsystem top level
`timescale 1ns/1ps
`default_nettype none
`include "cb_macros.svh"

module cb_top (
  input  wire logic             CLK,
  input  wire logic             nRST,
  // Issue port
  input  wire logic             issue_valid,
  input  wire logic             issue_mul,
  input  wire cb_pkg::reg_idx_t issue_rd,
  input  wire cb_pkg::word_t    issue_a,
  input  wire cb_pkg::word_t    issue_b,
  input  wire logic             issue_exc,
  // Register file read port
  input  wire cb_pkg::reg_idx_t rf_raddr,
  output cb_pkg::word_t         rf_rdata,
  // Buffer status and commit
  output logic                  full,
  output logic                  empty,
  output logic                  commit_valid,
  output cb_pkg::reg_idx_t      commit_rd,
  output cb_pkg::word_t         commit_data,
  output logic                  commit_exception
);

  cb_pkg::tag_t     alloc_tag;
  logic             flush;
  logic             rf_wen;
  logic             add_in_valid;
  logic             mul_in_valid;
  // Add unit writeback
  logic             add_valid;
  cb_pkg::tag_t     add_tag;
  cb_pkg::word_t    add_data;
  cb_pkg::reg_idx_t add_rd;
  logic             add_exc;
  // Multiply unit writeback
  logic             mul_valid;
  cb_pkg::tag_t     mul_tag;
  cb_pkg::word_t    mul_data;
  cb_pkg::reg_idx_t mul_rd;
  logic             mul_exc;

  // Steer an accepted issue to one unit
  assign add_in_valid = issue_valid & ~full & ~issue_mul;
  assign mul_in_valid = issue_valid & ~full & issue_mul;

  exec_unit #(.LATENCY(`CB_ADD_LAT), .MUL(1'b0)) add_unit (
    .CLK(CLK), .nRST(nRST), .flush(flush),
    .in_valid(add_in_valid), .in_tag(alloc_tag), .in_a(issue_a), .in_b(issue_b),
    .in_rd(issue_rd), .in_exc(issue_exc),
    .out_valid(add_valid), .out_tag(add_tag), .out_data(add_data),
    .out_rd(add_rd), .out_exc(add_exc)
  );

  exec_unit #(.LATENCY(`CB_MUL_LAT), .MUL(1'b1)) mul_unit (
    .CLK(CLK), .nRST(nRST), .flush(flush),
    .in_valid(mul_in_valid), .in_tag(alloc_tag), .in_a(issue_a), .in_b(issue_b),
    .in_rd(issue_rd), .in_exc(issue_exc),
    .out_valid(mul_valid), .out_tag(mul_tag), .out_data(mul_data),
    .out_rd(mul_rd), .out_exc(mul_exc)
  );

  completion_buffer cb_inst (
    .CLK(CLK), .nRST(nRST),
    .alloc(issue_valid), .alloc_rd(issue_rd), .alloc_exc(issue_exc),
    .add_valid(add_valid), .add_tag(add_tag), .add_data(add_data),
    .add_rd(add_rd), .add_exc(add_exc),
    .mul_valid(mul_valid), .mul_tag(mul_tag), .mul_data(mul_data),
    .mul_rd(mul_rd), .mul_exc(mul_exc),
    .alloc_tag(alloc_tag), .full(full), .empty(empty),
    .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_data(commit_data),
    .commit_exception(commit_exception), .rf_wen(rf_wen), .flush(flush)
  );

  // Commit port drives the single write port
  reg_file rf_inst (
    .CLK(CLK), .nRST(nRST),
    .wen(rf_wen), .waddr(commit_rd), .wdata(commit_data),
    .raddr(rf_raddr), .rdata(rf_rdata)
  );

endmodule

`default_nettype wire

//--- tb/cb_tb.sv
// Completion subsystem testbench
`timescale 1ns/1ps
`default_nettype none
`include "cb_macros.svh"

module cb_tb;

  localparam int DEPTH = `CB_DEPTH;
  localparam int N_RAND = 60;
  // Summed test lengths in cycles set the watchdog limit
  localparam int RUN_CYCLES = 40 + 20 + 30 + (N_RAND + 80) + 60;

  // One outstanding instruction as the model sees it
  typedef struct packed {
    cb_pkg::word_t    data;
    cb_pkg::reg_idx_t rd;
    logic             exc;
  } exp_item_t;

  logic             CLK, nRST, issue_valid, issue_mul, issue_exc;
  cb_pkg::reg_idx_t issue_rd, rf_raddr, commit_rd, exp_rd;
  cb_pkg::word_t    issue_a, issue_b, rf_rdata, commit_data, exp_data;
  logic             full, empty, commit_valid, commit_exception, exp_valid, exp_exc;
  logic             model_flush;
  exp_item_t        exp_q [$];
  exp_item_t        item;
  cb_pkg::word_t    exp_rf [32];
  int               exp_count, occ, base;
  int               err_count = 0;
  int               err_start = 0;
  int               pass_tests = 0;
  int               fail_tests = 0;
  int               commits = 0;
  int               exc_commits = 0;

  cb_top cb_top_inst (.*);

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  initial begin
    repeat (RUN_CYCLES * 20) @(posedge CLK);
    $display("Timeout: the tests did not finish within %0d cycles", RUN_CYCLES * 20);
    $display("Done: errors found");
    $finish;
  end

  // Reference model updated mid-cycle while DUT outputs are stable
  always @(negedge CLK or negedge nRST) begin
    if (!nRST) begin
      exp_q.delete();
      for (int r = 0; r < 32; r++) begin
        exp_rf[r] = '0;
      end
    end else begin
      occ = exp_q.size();
      model_flush = 1'b0;
      // Oldest entry leaves; an exception drops all younger work
      if (commit_valid && occ > 0) begin
        item = exp_q.pop_front();
        if (item.exc) begin
          model_flush = 1'b1;
          exp_q.delete();
          exc_commits++;
        end else begin
          commits++;
          if (item.rd != '0) begin
            exp_rf[item.rd] = item.data;
          end
        end
      end
      // Accepted when not full and not in the flush cycle
      if (issue_valid && occ < DEPTH && !model_flush) begin
        item.data = issue_mul ? issue_a * issue_b : issue_a + issue_b;
        item.rd   = issue_rd;
        item.exc  = issue_exc;
        exp_q.push_back(item);
      end
    end
    exp_count <= exp_q.size();
    exp_valid <= (exp_q.size() > 0);
    if (exp_q.size() > 0) begin
      exp_data <= exp_q[0].data;
      exp_rd   <= exp_q[0].rd;
      exp_exc  <= exp_q[0].exc;
    end
  end

  // Every commit matches the oldest outstanding instruction
  commit_order_a: assert property (@(negedge CLK) disable iff (!nRST)
      commit_valid |-> exp_valid && commit_exception == exp_exc)
    else begin
      $display("[ERROR] %0t: commit with no match or wrong exception flag", $time);
      err_count++;
    end
  commit_value_a: assert property (@(negedge CLK) disable iff (!nRST)
      commit_valid && !exp_exc |-> commit_rd == exp_rd && commit_data == exp_data)
    else begin
      $display("[ERROR] %0t: commit x%0d = %h, expected x%0d = %h", $time,
               commit_rd, commit_data, exp_rd, exp_data);
      err_count++;
    end
  // Full and empty follow the outstanding count
  status_a: assert property (@(negedge CLK) disable iff (!nRST)
      full == (exp_count == DEPTH) && empty == (exp_count == 0))
    else begin
      $display("[ERROR] %0t: full %b empty %b with %0d outstanding", $time,
               full, empty, exp_count);
      err_count++;
    end

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge CLK);
    #1;
  endtask

  task automatic issue_op(input logic mul, input cb_pkg::reg_idx_t rd,
                          input cb_pkg::word_t a, input cb_pkg::word_t b, input logic exc);
    issue_valid = 1'b1;
    issue_mul   = mul;
    issue_rd    = rd;
    issue_a     = a;
    issue_b     = b;
    issue_exc   = exc;
    next_cycle();
    issue_valid = 1'b0;
  endtask

  task automatic check_reg(input cb_pkg::reg_idx_t idx, input cb_pkg::word_t expected);
    rf_raddr = idx;
    #1;
    assert (rf_rdata == expected) else begin
      $display("[ERROR] %0t: x%0d reads %h, expected %h", $time, idx, rf_rdata, expected);
      err_count++;
    end
    next_cycle();
  endtask

  // Wait until model and DUT both hold no work
  task automatic wait_idle(input int limit);
    int n;
    n = 0;
    while (!(empty && exp_count == 0) && n < limit) begin
      next_cycle();
      n++;
    end
    if (!(empty && exp_count == 0)) begin
      $display("Buffer did not drain within %0d cycles", limit);
      err_count++;
    end
  endtask

  task automatic report_test(input string name);
    if (err_count == err_start) begin
      pass_tests++;
      $display("PASS %s", name);
    end else begin
      fail_tests++;
      $display("FAIL %s", name);
    end
    err_start = err_count;
  endtask

  initial begin
    void'($urandom(32'h960fbd1a));
    nRST        = 1'b0;
    issue_valid = 1'b0;
    issue_mul   = 1'b0;
    issue_exc   = 1'b0;
    issue_rd    = '0;
    issue_a     = '0;
    issue_b     = '0;
    rf_raddr    = '0;
    repeat (2) @(posedge CLK);
    #1;
    nRST = 1'b1;

    // Idle status and a cleared register file
    assert (empty && !full && !commit_valid && !commit_exception) else begin
      $display("[ERROR] %0t: status after reset is wrong", $time);
      err_count++;
    end
    for (int r = 0; r < 32; r++) begin
      check_reg(5'(r), '0);
    end
    report_test("reset state");

    // Add finishes before the older multiply but retires after it
    base = commits;
    issue_op(1'b1, 5'd3, 32'd1234, 32'd5678, 1'b0);
    issue_op(1'b0, 5'd4, 32'hffff_fff0, 32'd100, 1'b0);
    wait_idle(40);
    assert (commits == base + 2) else begin
      $display("[ERROR] %0t: %0d commits, expected 2", $time, commits - base);
      err_count++;
    end
    check_reg(5'd3, 32'd7006652);
    check_reg(5'd4, 32'd84);
    report_test("out-of-order completion");

    // Back-to-back multiplies plus one extra issue
    for (int i = 0; i <= DEPTH; i++) begin
      issue_op(1'b1, 5'(8 + i), $urandom, $urandom, 1'b0);
    end
    wait_idle(60);
    report_test("full and drain");

    // Random mix with idle gaps
    for (int i = 0; i < N_RAND; i++) begin
      if ($urandom_range(3) != 0) begin
        issue_op(1'($urandom_range(1)), 5'($urandom), $urandom, $urandom, 1'b0);
      end else begin
        next_cycle();
      end
    end
    wait_idle(80);
    for (int r = 1; r < 32; r++) begin
      check_reg(5'(r), exp_rf[r]);
    end
    check_reg(5'd0, '0);
    report_test("random streams");

    // Faulting multiply; the last add lands in the flush cycle
    base = exc_commits;
    issue_op(1'b1, 5'd20, 32'd7, 32'd9, 1'b1);
    for (int i = 0; i < 4; i++) begin
      issue_op(1'b0, 5'(21 + i), 32'(i), 32'd1, 1'b0);
    end
    wait_idle(40);
    assert (exc_commits == base + 1 && empty) else begin
      $display("[ERROR] %0t: exception did not commit and empty the buffer", $time);
      err_count++;
    end
    for (int r = 20; r < 25; r++) begin
      check_reg(5'(r), exp_rf[r]);
    end
    issue_op(1'b0, 5'd21, 32'd3, 32'd4, 1'b0);
    issue_op(1'b1, 5'd22, 32'd6, 32'd7, 1'b0);
    wait_idle(40);
    check_reg(5'd21, 32'd7);
    check_reg(5'd22, 32'd42);
    report_test("exception flush");

    $display("Tests: %0d passed, %0d failed, %0d errors", pass_tests, fail_tests, err_count);
    if (fail_tests == 0 && err_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+hdl
hdl/cb_pkg.sv
hdl/exec_unit.sv
hdl/reg_file.sv
hdl/completion_buffer.sv
hdl/cb_top.sv
tb/cb_tb.sv
